/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = coreTb
FILELIST = vlog.f
OBJDIR = obj_dir
SIM = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "Simulation completed successfully"

clean:
	rm -rf $(OBJDIR)

/* bench/coreChecker.sv */
`timescale 1ns/1ns

module coreChecker (
    input  logic          clk,
    input  logic          rst,
    input  logic          commitValid,
    input  logic          commitWb,
    input  logic          commitIllegal,
    input  rvCorePkg::u5  commitRd,
    input  rvCorePkg::u64 commitData,
    input  logic [31:0]   commitInstr,
    input  rvCorePkg::u64 commitAddr,
    input  logic          expPush,
    input  logic [31:0]   expInstr,
    input  rvCorePkg::u64 expAddr,
    input  logic          expWb,
    input  rvCorePkg::u5  expRd,
    input  rvCorePkg::u64 expData,
    input  logic          expIllegal,
    input  logic [127:0]  expName,
    output int            passCount,
    output int            failCount,
    output int            commitCount,
    output int            pending
);
    import rvCorePkg::*;

    typedef struct packed {
        logic [31:0] instr;
        u64 addr;
        logic wb;
        u5 rd;
        u64 data;
        logic illegal;
        logic [127:0] name;
    } expect_t;

    expect_t expQ[$]; // commits come back in issue order.

    initial begin
        passCount = 0;
        failCount = 0;
        commitCount = 0;
        pending = 0;
    end

    task automatic compareField(input string field, input logic [127:0] name,
                                input u64 expVal, input u64 gotVal, inout logic ok);
        if (expVal !== gotVal) begin
            $display("ERROR at %0t ns: %s %s expected %h got %h",
                     $time, name, field, expVal, gotVal);
            ok = 1'b0;
        end
    endtask

    always @(posedge clk) begin : watch
        expect_t e;
        logic ok;
        if (!rst && commitValid) begin
            commitCount <= commitCount + 1;
            if (expQ.size() == 0) begin
                $display("unexpected commit at %0t ns for address %h with no test queued",
                         $time, commitAddr);
                failCount <= failCount + 1;
            end else begin
                e = expQ.pop_front();
                ok = 1'b1;
                compareField("commitAddr", e.name, e.addr, commitAddr, ok);
                compareField("commitInstr", e.name, 64'(e.instr), 64'(commitInstr), ok);
                compareField("commitWb", e.name, 64'(e.wb), 64'(commitWb), ok);
                compareField("commitIllegal", e.name, 64'(e.illegal), 64'(commitIllegal), ok);
                compareField("commitData", e.name, e.data, commitData, ok);
                compareField("commitRd", e.name, 64'(e.rd), 64'(commitRd), ok);
                if (ok) begin
                    $display("PASS %s", e.name);
                    passCount <= passCount + 1;
                end else begin
                    $display("FAIL %s", e.name);
                    failCount <= failCount + 1;
                end
            end
        end
        if (!rst && expPush) begin
            expQ.push_back({expInstr, expAddr, expWb, expRd, expData, expIllegal, expName});
        end
        pending <= expQ.size();
    end

endmodule

/* bench/coreTb.sv */
`timescale 1ns/1ns

module coreTb;
    import rvCorePkg::*;

    typedef struct packed {
        logic tight;
        logic [31:0] word;
        u64 addr;
        logic wb;
        u5 rd;
        u64 data;
        logic illegal;
        logic [127:0] name;
    } testCase_t;

    testCase_t tests[$];

    logic clk;
    logic rst;
    logic instrValid;
    logic [31:0] instr;
    u64 instrAddr;
    logic commitValid;
    logic commitWb;
    logic commitIllegal;
    u5 commitRd;
    u64 commitData;
    logic [31:0] commitInstr;
    u64 commitAddr;

    logic expPush;
    logic [31:0] expInstr;
    u64 expAddr;
    logic expWb;
    u5 expRd;
    u64 expData;
    logic expIllegal;
    logic [127:0] expName;
    int passCount;
    int failCount;
    int commitCount;
    int pending;
    int cycles;
    int limit;

    rvCoreTop UUT (
        .clk, .rst, .instrValid, .instr, .instrAddr,
        .commitValid, .commitWb, .commitIllegal, .commitRd,
        .commitData, .commitInstr, .commitAddr
    );

    coreChecker check (
        .clk, .rst,
        .commitValid, .commitWb, .commitIllegal, .commitRd,
        .commitData, .commitInstr, .commitAddr,
        .expPush, .expInstr, .expAddr, .expWb, .expRd, .expData, .expIllegal, .expName,
        .passCount, .failCount, .commitCount, .pending
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input u5 rs2, input u5 rs1,
                                         input logic [2:0] f3, input u5 rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input u5 rs1,
                                         input logic [2:0] f3, input u5 rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encLui(input logic [19:0] imm, input u5 rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] encJal(input logic [20:0] off, input u5 rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] encCsrrw(input u12 csr, input u5 rs1, input u5 rd);
        return {csr, rs1, 3'b001, rd, 7'b1110011};
    endfunction

    task automatic addTest(input logic tight, input logic [31:0] word, input logic wb,
                           input u5 rd, input u64 data, input logic illegal,
                           input logic [127:0] name);
        testCase_t t;
        t.tight = tight;
        t.word = word;
        t.addr = 64'h1000 + 64'(tests.size()) * 64'd4;
        t.wb = wb;
        t.rd = rd;
        t.data = data;
        t.illegal = illegal;
        t.name = name;
        tests.push_back(t);
    endtask

    task automatic buildTable();
        addTest(0, encLui(20'h12345, 1), 1, 1, 64'h12345000, 0, "lui x1");
        addTest(1, encI(12'h678, 1, 3'b000, 1, 7'b0010011), 1, 1, 64'h12345678, 0, "addi x1");
        addTest(0, encI(12'hFFF, 0, 3'b000, 2, 7'b0010011), 1, 2, '1, 0, "addi negative");
        addTest(0, encI(12'h0F0, 0, 3'b000, 3, 7'b0010011), 1, 3, 64'hF0, 0, "addi x3");
        addTest(0, encR(7'h00, 2, 1, 3'b000, 4), 1, 4, 64'h12345677, 0, "add");
        addTest(0, encR(7'h20, 3, 1, 3'b000, 5), 1, 5, 64'h12345588, 0, "sub");
        addTest(0, encR(7'h00, 3, 1, 3'b111, 6), 1, 6, 64'h70, 0, "and");
        addTest(0, encR(7'h00, 3, 1, 3'b110, 7), 1, 7, 64'h123456F8, 0, "or");
        addTest(0, encR(7'h00, 2, 1, 3'b100, 8), 1, 8, 64'hFFFFFFFF_EDCBA987, 0, "xor");
        addTest(0, encI(12'h005, 0, 3'b000, 9, 7'b0010011), 1, 9, 64'd5, 0, "chain 1");
        addTest(1, encI(12'h007, 9, 3'b000, 9, 7'b0010011), 1, 9, 64'd12, 0, "chain 2 tight");
        addTest(1, encR(7'h00, 9, 9, 3'b000, 10), 1, 10, 64'd24, 0, "chain 3 tight");
        addTest(0, encI(12'h001, 1, 3'b000, 0, 7'b0010011), 0, 0, 64'd0, 0, "addi to x0");
        addTest(1, encR(7'h00, 1, 0, 3'b000, 11), 1, 11, 64'h12345678, 0, "read x0 tight");
        addTest(0, encJal(21'd16, 12), 1, 12, 64'h103C, 0, "jal link"); // sits at 0x1038.
        addTest(0, encCsrrw(CSR_MSCRATCH, 1, 13), 1, 13, 64'd0, 0, "csrrw first");
        addTest(1, encCsrrw(CSR_MSCRATCH, 3, 14), 1, 14, 64'h12345678, 0, "csrrw tight");
        addTest(0, encCsrrw(12'h7C0, 2, 15), 1, 15, 64'd0, 0, "csrrw unimpl");
        addTest(1, encCsrrw(12'h7C0, 3, 16), 1, 16, 64'd0, 0, "csrrw unimpl 2");
        addTest(0, encI(12'h000, 1, 3'b010, 5, 7'b0000011), 0, 5, 64'd0, 1, "illegal load");
        addTest(1, encR(7'h00, 4, 5, 3'b000, 17), 1, 17, 64'h2468ABFF, 0, "after illegal");
        addTest(0, encCsrrw(CSR_MSCRATCH, 0, 18), 1, 18, 64'hF0, 0, "csrrw read back");
    endtask

    task automatic driveIdle();
        instrValid <= 1'b0;
        expPush <= 1'b0;
    endtask

    initial begin
        int gap;
        clk = 1'b0;
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        instrAddr = '0;
        expPush = 1'b0;
        expInstr = '0;
        expAddr = '0;
        expWb = 1'b0;
        expRd = '0;
        expData = '0;
        expIllegal = 1'b0;
        expName = '0;
        cycles = 0;
        limit = 0;
        void'($urandom(82071));
        buildTable();
        limit = tests.size() * 4 + 20; // worst case gap plus issue cycle per entry.
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        foreach (tests[i]) begin
            gap = tests[i].tight ? 0 : int'($urandom % 4);
            repeat (gap) begin
                @(posedge clk);
                driveIdle();
            end
            @(posedge clk);
            instrValid <= 1'b1;
            instr <= tests[i].word;
            instrAddr <= tests[i].addr;
            expPush <= 1'b1;
            expInstr <= tests[i].word;
            expAddr <= tests[i].addr;
            expWb <= tests[i].wb;
            expRd <= tests[i].rd;
            expData <= tests[i].data;
            expIllegal <= tests[i].illegal;
            expName <= tests[i].name;
        end
        @(posedge clk);
        driveIdle();
        wait (commitCount >= tests.size());
        @(posedge clk);
        if (pending != 0) begin
            $display("%0d expected commits never arrived", pending);
        end
        $display("summary: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0 && pending == 0 && passCount == tests.size()) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* design/csrFile.sv */
`timescale 1ns/1ns

module csrFile (
    input  logic          clk,
    input  logic          rst,
    input  rvCorePkg::u12 csrRdAddr,
    output rvCorePkg::u64 csrRdData,
    input  logic          csrWbEn,
    input  rvCorePkg::u12 csrAddr,
    input  rvCorePkg::u64 csrValue
);
    import rvCorePkg::*;

    u64 mtvec;
    u64 mscratch;
    u64 mepc;

    always_comb begin
        case (csrRdAddr)
            CSR_MTVEC: csrRdData = mtvec;
            CSR_MSCRATCH: csrRdData = mscratch;
            CSR_MEPC: csrRdData = mepc;
            default: csrRdData = '0; // unimplemented reads zero.
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtvec <= '0;
            mscratch <= '0;
            mepc <= '0;
        end else if (csrWbEn) begin
            if (csrAddr == CSR_MTVEC) mtvec <= csrValue;
            if (csrAddr == CSR_MSCRATCH) mscratch <= csrValue;
            if (csrAddr == CSR_MEPC) mepc <= csrValue;
        end
    end

endmodule

/* design/decodeStage.sv */
`timescale 1ns/1ns

module decodeStage (
    input  logic               clk,
    input  logic               rst,
    input  logic               instrValid,
    input  logic [31:0]        instr,
    input  rvCorePkg::u64      instrAddr,
    output logic               decValid,
    output rvCorePkg::opKind_e decKind,
    output rvCorePkg::aluOp_e  decAluOp,
    output rvCorePkg::u5       decRd,
    output rvCorePkg::u5       decRs1,
    output rvCorePkg::u5       decRs2,
    output rvCorePkg::u64      decImm,
    output rvCorePkg::u12      decCsrAddr,
    output logic [31:0]        decInstr,
    output rvCorePkg::u64      decInstrAddr
);
    import rvCorePkg::*;

    opKind_e kind;
    aluOp_e aluOp;
    u64 imm;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        kind = OP_ILLEGAL;
        aluOp = ALU_ADD;
        imm = '0;
        case (opcode)
            OPC_OP: begin
                kind = OP_ALU_R;
                if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    aluOp = ALU_SUB;
                end else if (funct7 != 7'b0000000) begin
                    kind = OP_ILLEGAL;
                end else begin
                    case (funct3)
                        3'b000: aluOp = ALU_ADD;
                        3'b100: aluOp = ALU_XOR;
                        3'b110: aluOp = ALU_OR;
                        3'b111: aluOp = ALU_AND;
                        default: kind = OP_ILLEGAL; // shifts and compares.
                    endcase
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin
                    kind = OP_ALU_I; // addi only.
                    imm = immI(instr);
                end
            end
            OPC_LUI: begin
                kind = OP_LUI;
                imm = immU(instr);
            end
            OPC_JAL: begin
                kind = OP_JAL;
                imm = immJ(instr); // carried along, no redirect.
            end
            OPC_SYSTEM: begin
                if (funct3 == 3'b001) begin
                    kind = OP_CSRRW;
                end
            end
            default: kind = OP_ILLEGAL;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            decValid <= 1'b0;
        end else begin
            decValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        decKind <= kind;
        decAluOp <= aluOp;
        decRd <= instr[11:7]; // x0 kept, writeback drops it.
        decRs1 <= instr[19:15];
        decRs2 <= instr[24:20];
        decImm <= imm;
        decCsrAddr <= instr[31:20];
        decInstr <= instr;
        decInstrAddr <= instrAddr;
    end

endmodule

/* design/executeStage.sv */
`timescale 1ns/1ns

module executeStage (
    input  logic               clk,
    input  logic               rst,
    input  logic               decValid,
    input  rvCorePkg::opKind_e decKind,
    input  rvCorePkg::aluOp_e  decAluOp,
    input  rvCorePkg::u5       decRd,
    input  rvCorePkg::u5       decRs1,
    input  rvCorePkg::u5       decRs2,
    input  rvCorePkg::u64      decImm,
    input  rvCorePkg::u12      decCsrAddr,
    input  logic [31:0]        decInstr,
    input  rvCorePkg::u64      decInstrAddr,
    output rvCorePkg::u5       rs1,
    output rvCorePkg::u5       rs2,
    input  rvCorePkg::u64      rs1Data,
    input  rvCorePkg::u64      rs2Data,
    output rvCorePkg::u12      csrRdAddr,
    input  rvCorePkg::u64      csrRdData,
    output logic               exValid,
    output rvCorePkg::opKind_e exKind,
    output rvCorePkg::u5       exRd,
    output rvCorePkg::u64      exResult,
    output rvCorePkg::u12      exCsrAddr,
    output rvCorePkg::u64      exCsrData,
    output logic [31:0]        exInstr,
    output rvCorePkg::u64      exInstrAddr
);
    import rvCorePkg::*;

    logic exWritesReg;
    logic fwdCsr;
    u64 opA;
    u64 opB;
    u64 csrOld;
    u64 result;

    function automatic u64 aluCompute(input aluOp_e op, input u64 a, input u64 b);
        case (op)
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR: return a | b;
            ALU_XOR: return a ^ b;
            default: return a + b;
        endcase
    endfunction

    assign rs1 = decRs1;
    assign rs2 = decRs2;
    assign csrRdAddr = decCsrAddr;

    // the instruction ahead has not reached storage yet.
    assign exWritesReg = exValid && exKind != OP_ILLEGAL && exRd != 5'd0;
    assign opA = (exWritesReg && exRd == decRs1) ? exResult : rs1Data;
    assign opB = (exWritesReg && exRd == decRs2) ? exResult : rs2Data;

    assign fwdCsr = exValid && exKind == OP_CSRRW && exCsrAddr == decCsrAddr
                    && csrImplemented(exCsrAddr); // unimplemented csrs stay zero.
    assign csrOld = fwdCsr ? exCsrData : csrRdData;

    always_comb begin
        case (decKind)
            OP_ALU_R: result = aluCompute(decAluOp, opA, opB);
            OP_ALU_I: result = aluCompute(decAluOp, opA, decImm);
            OP_LUI: result = decImm;
            OP_JAL: result = decInstrAddr + 64'd4; // link value.
            OP_CSRRW: result = csrOld;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exValid <= 1'b0;
        end else begin
            exValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        exKind <= decKind;
        exRd <= decRd;
        exResult <= result;
        exCsrAddr <= decCsrAddr;
        exCsrData <= opA; // new csr value is rs1.
        exInstr <= decInstr;
        exInstrAddr <= decInstrAddr;
    end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ns

module regFile (
    input  logic          clk,
    input  logic          rst,
    input  rvCorePkg::u5  rs1,
    input  rvCorePkg::u5  rs2,
    output rvCorePkg::u64 rs1Data,
    output rvCorePkg::u64 rs2Data,
    input  logic          wbEn,
    input  rvCorePkg::u5  wd,
    input  rvCorePkg::u64 wbData
);
    import rvCorePkg::*;

    u64 regs [NUM_REGS];

    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wd != 5'd0) begin
            regs[wd] <= wbData; // x0 never written.
        end
    end

endmodule

/* design/rvCorePkg.sv */
package rvCorePkg;

    localparam int XLEN = 64;
    localparam int NUM_REGS = 32;

    localparam logic [11:0] CSR_MTVEC = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC = 12'h341;

    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef logic [XLEN-1:0] u64;
    typedef logic [11:0] u12;
    typedef logic [4:0] u5;

    typedef enum logic [2:0] {
        OP_ALU_R,
        OP_ALU_I,
        OP_LUI,
        OP_JAL,
        OP_CSRRW,
        OP_ILLEGAL
    } opKind_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } aluOp_e;

    function automatic u64 immI(input logic [31:0] instr);
        return {{52{instr[31]}}, instr[31:20]};
    endfunction

    function automatic u64 immU(input logic [31:0] instr);
        return {{32{instr[31]}}, instr[31:12], 12'b0};
    endfunction

    function automatic u64 immJ(input logic [31:0] instr);
        return {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    endfunction

    // only these three addresses hold state.
    function automatic logic csrImplemented(input u12 addr);
        return addr == CSR_MTVEC || addr == CSR_MSCRATCH || addr == CSR_MEPC;
    endfunction

endpackage

/* design/rvCoreTop.sv */
`timescale 1ns/1ns

module rvCoreTop (
    input  logic          clk,
    input  logic          rst,
    input  logic          instrValid,
    input  logic [31:0]   instr,
    input  rvCorePkg::u64 instrAddr,
    output logic          commitValid,
    output logic          commitWb,
    output logic          commitIllegal,
    output rvCorePkg::u5  commitRd,
    output rvCorePkg::u64 commitData,
    output logic [31:0]   commitInstr,
    output rvCorePkg::u64 commitAddr
);
    import rvCorePkg::*;

    logic decValid;
    opKind_e decKind;
    aluOp_e decAluOp;
    u5 decRd;
    u5 decRs1;
    u5 decRs2;
    u64 decImm;
    u12 decCsrAddr;
    logic [31:0] decInstr;
    u64 decInstrAddr;

    u5 rs1;
    u5 rs2;
    u64 rs1Data;
    u64 rs2Data;
    u12 csrRdAddr;
    u64 csrRdData;

    logic exValid;
    opKind_e exKind;
    u5 exRd;
    u64 exResult;
    u12 exCsrAddr;
    u64 exCsrData;
    logic [31:0] exInstr;
    u64 exInstrAddr;

    logic wbEn;
    u5 wd;
    u64 wbData;
    logic csrWbEn;
    u12 csrAddr;
    u64 csrValue;

    decodeStage decode (
        .clk, .rst, .instrValid, .instr, .instrAddr,
        .decValid, .decKind, .decAluOp, .decRd, .decRs1, .decRs2,
        .decImm, .decCsrAddr, .decInstr, .decInstrAddr
    );

    executeStage execute (
        .clk, .rst,
        .decValid, .decKind, .decAluOp, .decRd, .decRs1, .decRs2,
        .decImm, .decCsrAddr, .decInstr, .decInstrAddr,
        .rs1, .rs2, .rs1Data, .rs2Data, .csrRdAddr, .csrRdData,
        .exValid, .exKind, .exRd, .exResult,
        .exCsrAddr, .exCsrData, .exInstr, .exInstrAddr
    );

    writebackStage writeback (
        .clk, .rst,
        .exValid, .exKind, .exRd, .exResult,
        .exCsrAddr, .exCsrData, .exInstr, .exInstrAddr,
        .wbEn, .wd, .wbData, .csrWbEn, .csrAddr, .csrValue,
        .commitValid, .commitWb, .commitIllegal, .commitRd,
        .commitData, .commitInstr, .commitAddr
    );

    regFile regs (
        .clk, .rst, .rs1, .rs2, .rs1Data, .rs2Data, .wbEn, .wd, .wbData
    );

    csrFile csrs (
        .clk, .rst, .csrRdAddr, .csrRdData, .csrWbEn, .csrAddr, .csrValue
    );

endmodule

/* design/writebackStage.sv */
`timescale 1ns/1ns

module writebackStage (
    input  logic               clk,
    input  logic               rst,
    input  logic               exValid,
    input  rvCorePkg::opKind_e exKind,
    input  rvCorePkg::u5       exRd,
    input  rvCorePkg::u64      exResult,
    input  rvCorePkg::u12      exCsrAddr,
    input  rvCorePkg::u64      exCsrData,
    input  logic [31:0]        exInstr,
    input  rvCorePkg::u64      exInstrAddr,
    output logic               wbEn,
    output rvCorePkg::u5       wd,
    output rvCorePkg::u64      wbData,
    output logic               csrWbEn,
    output rvCorePkg::u12      csrAddr,
    output rvCorePkg::u64      csrValue,
    output logic               commitValid,
    output logic               commitWb,
    output logic               commitIllegal,
    output rvCorePkg::u5       commitRd,
    output rvCorePkg::u64      commitData,
    output logic [31:0]        commitInstr,
    output rvCorePkg::u64      commitAddr
);
    import rvCorePkg::*;

    logic isIllegal;

    assign isIllegal = exValid && exKind == OP_ILLEGAL;

    // storage picks these up on the next edge.
    assign wbEn = exValid && exKind != OP_ILLEGAL && exRd != 5'd0;
    assign wd = exRd;
    assign wbData = exResult;

    assign csrWbEn = exValid && exKind == OP_CSRRW;
    assign csrAddr = exCsrAddr;
    assign csrValue = exCsrData;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commitValid <= 1'b0;
            commitWb <= 1'b0;
            commitIllegal <= 1'b0;
        end else begin
            commitValid <= exValid;
            commitWb <= wbEn;
            commitIllegal <= isIllegal;
        end
    end

    always_ff @(posedge clk) begin
        commitRd <= exRd;
        commitData <= wbEn ? exResult : '0; // zero when nothing is written.
        commitInstr <= exInstr;
        commitAddr <= exInstrAddr;
    end

endmodule

/* vlog.f */
design/rvCorePkg.sv
design/regFile.sv
design/csrFile.sv
design/decodeStage.sv
design/executeStage.sv
design/writebackStage.sv
design/rvCoreTop.sv
bench/coreChecker.sv
bench/coreTb.sv
